/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_pkg.sv
  - rv_fetch.sv
  - rv_instr_buf.sv
  - rv_regs.sv
  - rv_exec.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv

/* filelist.f */
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_instr_buf.sv
rv_regs.sv
rv_exec.sv
rv_core.sv
tb_rv_core.sv

/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// byte address of the first fetch.
`define RV_RESET_ADDR       32'h0000_0000

// instruction byte-address width.
`define RV_IADDR_BITS       16

// instruction buffer holds 2**N words.
`define RV_IBUF_DEPTH_LOG2  2

// integer register count.
`define RV_NUM_REGS         32

`endif

/* rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_core (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    // instruction bus.
    output logic                        o_instr_req,
    output logic[`RV_IADDR_BITS-1:0]    o_instr_addr,
    input  logic                        i_instr_ack,
    input  logic[31:0]                  i_instr_data,
    // retire port.
    output logic                        o_retire_valid,
    output rv_pkg::rv_retire_t          o_retire,
    input  logic                        i_retire_ready
);

    import rv_pkg::*;

    logic               fetch_valid;
    logic               fetch_ready;
    rv_fetch_item_t     fetch_item;
    logic               ibuf_valid;
    logic               ibuf_ready;
    rv_fetch_item_t     ibuf_item;
    logic[4:0]          reg_rs1;
    logic[4:0]          reg_rs2;
    logic[31:0]         reg_data1;
    logic[31:0]         reg_data2;
    logic               reg_write;
    logic[4:0]          reg_rd;
    logic[31:0]         reg_wdata;

    rv_fetch u_fetch (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_instr_ack        (i_instr_ack),
        .i_instr_data       (i_instr_data),
        .o_instr_req        (o_instr_req),
        .o_instr_addr       (o_instr_addr),
        .o_valid            (fetch_valid),
        .o_item             (fetch_item),
        .i_ready            (fetch_ready)
    );

    rv_instr_buf #(
        .DEPTH_LOG2         (`RV_IBUF_DEPTH_LOG2)
    ) u_ibuf (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_valid            (fetch_valid),
        .i_item             (fetch_item),
        .o_ready            (fetch_ready),
        .o_valid            (ibuf_valid),
        .o_item             (ibuf_item),
        .i_ready            (ibuf_ready)
    );

    rv_exec u_exec (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_valid            (ibuf_valid),
        .i_item             (ibuf_item),
        .o_ready            (ibuf_ready),
        .o_rs1              (reg_rs1),
        .o_rs2              (reg_rs2),
        .i_data1            (reg_data1),
        .i_data2            (reg_data2),
        .o_reg_write        (reg_write),
        .o_rd               (reg_rd),
        .o_reg_data         (reg_wdata),
        .o_retire_valid     (o_retire_valid),
        .o_retire           (o_retire),
        .i_retire_ready     (i_retire_ready)
    );

    rv_regs u_regs (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_rs1              (reg_rs1),
        .i_rs2              (reg_rs2),
        .o_data1            (reg_data1),
        .o_data2            (reg_data2),
        .i_write            (reg_write),
        .i_rd               (reg_rd),
        .i_data             (reg_wdata)
    );

endmodule

`default_nettype wire

/* rv_exec.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_exec (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  rv_pkg::rv_fetch_item_t  i_item,
    output logic                    o_ready,
    output logic[4:0]               o_rs1,
    output logic[4:0]               o_rs2,
    input  logic[31:0]              i_data1,
    input  logic[31:0]              i_data2,
    output logic                    o_reg_write,
    output logic[4:0]               o_rd,
    output logic[31:0]              o_reg_data,
    output logic                    o_retire_valid,
    output rv_pkg::rv_retire_t      o_retire,
    input  logic                    i_retire_ready
);

    import rv_pkg::*;

    rv_opcode_e     opcode;
    rv_alu_op_e     alu_op;
    logic[2:0]      funct3;
    logic[6:0]      funct7;
    logic[31:0]     imm_i;
    logic[31:0]     op2;
    logic[31:0]     alu_res;
    logic[31:0]     result;
    logic           use_imm;
    logic           is_lui;
    logic           legal;
    logic           wrote;
    logic           pop;

    assign opcode = rv_opcode_e'(i_item.instr[6:0]);
    assign funct3 = i_item.instr[14:12];
    assign funct7 = i_item.instr[31:25];
    assign imm_i = {{20{i_item.instr[31]}}, i_item.instr[31:20]};

    always_comb begin
        legal = 1'b1;
        use_imm = 1'b0;
        is_lui = 1'b0;
        alu_op = alu_add;
        case (opcode)
            op_reg, op_imm: begin
                use_imm = (opcode == op_imm);
                case (funct3)
                    3'b000: alu_op = (!use_imm && funct7[5]) ? alu_sub : alu_add;
                    3'b010: alu_op = alu_slt;
                    3'b100: alu_op = alu_xor;
                    3'b110: alu_op = alu_or;
                    3'b111: alu_op = alu_and;
                    default: legal = 1'b0;
                endcase
                // register ops allow funct7 of zero, or 0100000 for sub.
                if (!use_imm && (funct7 != 7'b0000000) &&
                        !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    legal = 1'b0;
                end
            end
            op_lui: begin
                is_lui = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    assign op2 = use_imm ? imm_i : i_data2;

    always_comb begin
        case (alu_op)
            alu_sub: alu_res = i_data1 - op2;
            alu_and: alu_res = i_data1 & op2;
            alu_or:  alu_res = i_data1 | op2;
            alu_xor: alu_res = i_data1 ^ op2;
            alu_slt: alu_res = {31'd0, $signed(i_data1) < $signed(op2)};
            default: alu_res = i_data1 + op2;
        endcase
    end

    assign result = !legal ? '0 : (is_lui ? {i_item.instr[31:12], 12'd0} : alu_res);
    assign wrote = legal && (o_rd != 5'd0);

    // pop when retire slot is free or draining.
    assign o_ready = !o_retire_valid || i_retire_ready;
    assign pop = i_valid && o_ready;

    assign o_rs1 = i_item.instr[19:15];
    assign o_rs2 = i_item.instr[24:20];
    assign o_rd = i_item.instr[11:7];
    assign o_reg_write = pop && wrote;
    assign o_reg_data = result;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_retire_valid <= 1'b0;
        end else if (pop) begin
            o_retire_valid <= 1'b1;
        end else if (i_retire_ready) begin
            o_retire_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop) begin
            o_retire.pc <= i_item.pc;
            o_retire.rd <= o_rd;
            o_retire.result <= result;
            o_retire.wrote <= wrote;
            o_retire.illegal <= !legal;
            o_retire.instr <= {2'b00, i_item.instr[31:7]};
        end
    end

    a_retire_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && !i_retire_ready |=> o_retire_valid && $stable(o_retire)
    );

endmodule

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_fetch (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_instr_ack,
    input  logic[31:0]                  i_instr_data,
    output logic                        o_instr_req,
    output logic[`RV_IADDR_BITS-1:0]    o_instr_addr,
    output logic                        o_valid,
    output rv_pkg::rv_fetch_item_t      o_item,
    input  logic                        i_ready
);

    import rv_pkg::*;

    rv_fetch_state_e            state;
    logic[`RV_IADDR_BITS-1:0]   pc;
    rv_fetch_item_t             hold;
    logic                       hold_valid;
    logic                       hold_free;
    logic                       taken;

    // holding register empty or handed over this cycle.
    assign hold_free = !hold_valid || i_ready;
    assign taken = (state == fetch_wait) && i_instr_ack;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= fetch_idle;
            pc <= `RV_IADDR_BITS'(`RV_RESET_ADDR);
        end else begin
            case (state)
                fetch_idle: begin
                    if (hold_free) begin
                        state <= fetch_wait;
                    end
                end
                fetch_wait: begin
                    if (i_instr_ack) begin
                        state <= fetch_idle;
                        pc <= pc + `RV_IADDR_BITS'(4);
                    end
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            hold_valid <= 1'b0;
        end else if (taken) begin
            hold_valid <= 1'b1;
        end else if (i_ready) begin
            hold_valid <= 1'b0;
        end
    end

    // word is tagged with the pc it was fetched from.
    always_ff @(posedge i_clk) begin
        if (taken) begin
            hold.pc <= pc;
            hold.instr <= i_instr_data;
        end
    end

    assign o_instr_req = (state == fetch_wait);
    assign o_instr_addr = pc;
    assign o_valid = hold_valid;
    assign o_item = hold;

    a_addr_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_instr_req && !i_instr_ack |=> o_instr_req && $stable(o_instr_addr)
    );

endmodule

`default_nettype wire

/* rv_instr_buf.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_instr_buf #(
    parameter int DEPTH_LOG2 = `RV_IBUF_DEPTH_LOG2
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  rv_pkg::rv_fetch_item_t  i_item,
    output logic                    o_ready,
    output logic                    o_valid,
    output rv_pkg::rv_fetch_item_t  o_item,
    input  logic                    i_ready
);

    import rv_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    rv_fetch_item_t         mem[DEPTH];
    logic[DEPTH_LOG2-1:0]   wr_ptr;
    logic[DEPTH_LOG2-1:0]   rd_ptr;
    logic[DEPTH_LOG2:0]     count;
    logic                   push;
    logic                   pop;

    assign o_ready = (count != (DEPTH_LOG2 + 1)'(DEPTH));
    assign o_valid = (count != '0);
    assign push = i_valid && o_ready;
    assign pop = o_valid && i_ready;

    // head comes straight from storage.
    assign o_item = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_item;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        count <= (DEPTH_LOG2 + 1)'(DEPTH)
    );

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

    // RV32I major opcodes handled by execute.
    typedef enum logic[6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } rv_opcode_e;

    typedef enum logic[2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } rv_alu_op_e;

    typedef enum logic {
        fetch_idle = 1'b0,
        fetch_wait = 1'b1
    } rv_fetch_state_e;

    typedef struct packed {
        logic[`RV_IADDR_BITS-1:0]   pc;
        logic[31:0]                 instr;
    } rv_fetch_item_t;

    // instr keeps the word above the opcode field.
    typedef struct packed {
        logic[`RV_IADDR_BITS-1:0]   pc;
        logic[4:0]                  rd;
        logic[31:0]                 result;
        logic                       wrote;
        logic                       illegal;
        logic[26:0]                 instr;
    } rv_retire_t;

endpackage

`default_nettype wire

/* rv_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module rv_regs (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic[4:0]   i_rs1,
    input  logic[4:0]   i_rs2,
    output logic[31:0]  o_data1,
    output logic[31:0]  o_data2,
    input  logic        i_write,
    input  logic[4:0]   i_rd,
    input  logic[31:0]  i_data
);

    logic[31:0] regs[`RV_NUM_REGS];

    // x0 is cleared at reset and never written.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_data;
        end
    end

    assign o_data1 = regs[i_rs1];
    assign o_data2 = regs[i_rs2];

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_core;

    import rv_pkg::*;

    localparam int N_INSTR = 64;
    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT_CYCLES = N_INSTR * 8 + RESET_CYCLES;
    localparam int STALL_LIMIT = 32;
    localparam logic[6:0] OPC_REG = 7'h33;
    localparam logic[6:0] OPC_IMM = 7'h13;
    localparam logic[6:0] OPC_LUI = 7'h37;
    localparam logic[6:0] OPC_LOAD = 7'h03;
    localparam logic[31:0] FILLER = 32'h0000_0013;

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       o_instr_req;
    logic[`RV_IADDR_BITS-1:0]   o_instr_addr;
    logic                       i_instr_ack;
    logic[31:0]                 i_instr_data;
    logic                       o_retire_valid;
    rv_retire_t                 o_retire;
    logic                       i_retire_ready;

    logic[31:0]                 prog[N_INSTR];
    logic[31:0]                 gregs[32];
    logic[31:0]                 rng;
    logic[31:0]                 exp_result;
    logic[4:0]                  exp_rd;
    logic[26:0]                 exp_instr;
    logic                       exp_illegal;
    logic                       exp_wrote;
    logic[`RV_IADDR_BITS-1:0]   exp_pc;
    logic[`RV_IADDR_BITS-1:0]   last_ack_addr;
    logic                       req_seen;
    logic                       ack_seen;
    logic                       stall_done;
    int                         ret_idx;
    int                         ack_wait;
    int                         stall_left;
    int                         stall_len;
    int                         cycle_cnt;
    int                         checks[1:6];
    int                         errs[1:6];
    int                         total_checks;
    int                         total_errs;

    rv_core u_rv_core (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .o_instr_req        (o_instr_req),
        .o_instr_addr       (o_instr_addr),
        .i_instr_ack        (i_instr_ack),
        .i_instr_data       (i_instr_data),
        .o_retire_valid     (o_retire_valid),
        .o_retire           (o_retire),
        .i_retire_ready     (i_retire_ready)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic[31:0] lcg_next(input logic[31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic[31:0] r_word(input logic[6:0] f7, input logic[4:0] rs2,
            input logic[4:0] rs1, input logic[2:0] f3, input logic[4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic[31:0] i_word(input logic[11:0] imm, input logic[4:0] rs1,
            input logic[2:0] f3, input logic[4:0] rd, input logic[6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic[31:0] u_word(input logic[19:0] imm, input logic[4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic build_program();
        prog[0] = u_word(20'h12345, 1);
        prog[1] = i_word(12'd100, 0, 3'b000, 2, OPC_IMM);
        prog[2] = i_word(12'hff9, 0, 3'b000, 3, OPC_IMM);
        prog[3] = r_word(7'h00, 2, 1, 3'b000, 4);
        prog[4] = r_word(7'h20, 3, 2, 3'b000, 5);
        prog[5] = r_word(7'h00, 3, 1, 3'b111, 6);
        prog[6] = r_word(7'h00, 3, 2, 3'b110, 7);
        prog[7] = r_word(7'h00, 2, 1, 3'b100, 8);
        prog[8] = r_word(7'h00, 2, 3, 3'b010, 9);
        prog[9] = r_word(7'h00, 3, 2, 3'b010, 10);
        prog[10] = i_word(12'hf00, 4, 3'b110, 11, OPC_IMM);
        prog[11] = i_word(12'h0f0, 4, 3'b111, 12, OPC_IMM);
        prog[12] = i_word(12'h555, 3, 3'b100, 13, OPC_IMM);
        prog[13] = i_word(12'hffb, 3, 3'b010, 14, OPC_IMM);
        prog[14] = i_word(12'd50, 2, 3'b010, 15, OPC_IMM);
        // x0 targets, then reads of x0.
        prog[15] = i_word(12'd5, 2, 3'b000, 0, OPC_IMM);
        prog[16] = r_word(7'h00, 2, 0, 3'b000, 16);
        prog[17] = u_word(20'hfffff, 0);
        prog[18] = r_word(7'h00, 0, 0, 3'b110, 17);
        // a load and a mul, then reads of the registers they name.
        prog[19] = i_word(12'h000, 1, 3'b010, 18, OPC_LOAD);
        prog[20] = r_word(7'h00, 2, 18, 3'b000, 19);
        prog[21] = r_word(7'h01, 2, 1, 3'b000, 5);
        prog[22] = r_word(7'h20, 0, 5, 3'b000, 20);
        prog[23] = i_word(12'h800, 1, 3'b000, 21, OPC_IMM);
        prog[24] = r_word(7'h00, 21, 4, 3'b100, 22);
        for (int i = 25; i < N_INSTR; i++) begin
            prog[i] = FILLER;
        end
    endtask

    task automatic report_test(input int n, input string name);
        $display("test %0d %s: %0d checks, %0d errors", n, name, checks[n], errs[n]);
    endtask

    // golden model of the instruction at the retire head.
    always_comb begin : golden
        logic[31:0] w;
        logic[31:0] a;
        logic[31:0] b;
        logic[2:0]  f3;
        w = (ret_idx < N_INSTR) ? prog[ret_idx[5:0]] : FILLER;
        f3 = w[14:12];
        a = gregs[w[19:15]];
        b = (w[6:0] == OPC_IMM) ? {{20{w[31]}}, w[31:20]} : gregs[w[24:20]];
        exp_rd = w[11:7];
        exp_instr = 27'(w >> 7);
        exp_illegal = 1'b0;
        exp_result = '0;
        if (w[6:0] == OPC_LUI) begin
            exp_result = {w[31:12], 12'd0};
        end else if (w[6:0] == OPC_REG || w[6:0] == OPC_IMM) begin
            if (w[6:0] == OPC_REG && w[31:25] != 7'h00 && !(w[31:25] == 7'h20 && f3 == 3'b000)) begin
                exp_illegal = 1'b1;
            end
            case (f3)
                3'b000: exp_result = (w[6:0] == OPC_REG && w[30]) ? a - b : a + b;
                3'b010: exp_result = {31'd0, $signed(a) < $signed(b)};
                3'b100: exp_result = a ^ b;
                3'b110: exp_result = a | b;
                3'b111: exp_result = a & b;
                default: exp_illegal = 1'b1;
            endcase
        end else begin
            exp_illegal = 1'b1;
        end
        exp_wrote = !exp_illegal && (exp_rd != 5'd0);
        exp_pc = `RV_IADDR_BITS'(ret_idx * 4) + `RV_IADDR_BITS'(`RV_RESET_ADDR);
    end

    // memory model and retire back-pressure.
    always @(posedge i_clk) begin
        #2;
        i_instr_ack = 1'b0;
        if (o_instr_req) begin
            if (ack_wait < 0) begin
                rng = lcg_next(rng);
                ack_wait = int'(rng[17:16]);
            end
            if (ack_wait == 0) begin
                i_instr_ack = 1'b1;
                i_instr_data = (o_instr_addr < 16'd256) ? prog[o_instr_addr[7:2]] : FILLER;
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
        rng = lcg_next(rng);
        if (!stall_done && ret_idx >= 20) begin
            stall_left = STALL_LIMIT + 12;
            stall_done = 1'b1;
        end
        if (stall_left > 0) begin
            i_retire_ready = 1'b0;
            stall_left--;
        end else begin
            i_retire_ready = (rng[17:16] != 2'd0);
        end
    end

    always @(posedge i_clk) begin : monitor
        if (!i_rst_n) begin
            ret_idx <= 0;
            req_seen <= 1'b0;
            ack_seen <= 1'b0;
            stall_len <= 0;
            for (int k = 0; k < 32; k++) begin
                gregs[k] <= '0;
            end
        end else begin
            if (o_instr_req) begin
                req_seen <= 1'b1;
                checks[2]++;
                if (!req_seen) begin
                    checks[1]++;
                end
            end
            if (o_instr_req && i_instr_ack) begin
                ack_seen <= 1'b1;
                last_ack_addr <= o_instr_addr;
            end
            stall_len <= (o_retire_valid && !i_retire_ready) ? stall_len + 1 : 0;
            if (stall_len >= STALL_LIMIT) begin
                checks[4]++;
            end
            if (o_retire_valid && i_retire_ready) begin
                checks[3]++;
                if (exp_illegal) begin
                    checks[5]++;
                end else if (exp_rd == 5'd0) begin
                    checks[6]++;
                end
                if (exp_wrote) begin
                    gregs[exp_rd] <= exp_result;
                end
                ret_idx <= ret_idx + 1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !o_retire_valid)
        else begin
            errs[1]++;
            $display("error at %0t: o_retire_valid = %b, expected 0", $time,
                $sampled(o_retire_valid));
        end

    a_first_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_instr_req && !req_seen |-> o_instr_addr == `RV_IADDR_BITS'(`RV_RESET_ADDR))
        else begin
            errs[1]++;
            $display("error at %0t: o_instr_addr = %h, expected %h", $time,
                $sampled(o_instr_addr), `RV_IADDR_BITS'(`RV_RESET_ADDR));
        end

    a_addr_next: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_instr_req && ack_seen |-> o_instr_addr == last_ack_addr + 16'd4)
        else begin
            errs[2]++;
            $display("error at %0t: o_instr_addr = %h, expected %h", $time,
                $sampled(o_instr_addr), $sampled(last_ack_addr) + 16'd4);
        end

    a_addr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_instr_req && !i_instr_ack |=> o_instr_req && $stable(o_instr_addr))
        else begin
            errs[2]++;
            $display("instruction request dropped or moved before ack at %0t", $time);
        end

    a_retire_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && i_retire_ready |-> o_retire.pc == exp_pc)
        else begin
            errs[3]++;
            $display("error at %0t: o_retire.pc = %h, expected %h", $time,
                $sampled(o_retire.pc), $sampled(exp_pc));
        end

    a_retire_rd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && i_retire_ready |-> o_retire.rd == exp_rd)
        else begin
            errs[3]++;
            $display("error at %0t: o_retire.rd = %0d, expected %0d", $time,
                $sampled(o_retire.rd), $sampled(exp_rd));
        end

    a_retire_instr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && i_retire_ready |-> o_retire.instr == exp_instr)
        else begin
            errs[3]++;
            $display("error at %0t: o_retire.instr = %h, expected %h", $time,
                $sampled(o_retire.instr), $sampled(exp_instr));
        end

    a_retire_result: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && i_retire_ready && !exp_illegal |-> o_retire.result == exp_result)
        else begin
            errs[3]++;
            $display("error at %0t: o_retire.result = %h, expected %h", $time,
                $sampled(o_retire.result), $sampled(exp_result));
        end

    a_retire_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && !i_retire_ready |=> o_retire_valid && $stable(o_retire))
        else begin
            errs[4]++;
            $display("retire output changed while stalled at %0t", $time);
        end

    a_req_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        stall_len >= STALL_LIMIT |-> !o_instr_req)
        else begin
            errs[4]++;
            $display("bus request still active after a long retire stall at %0t", $time);
        end

    a_illegal_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && i_retire_ready |-> o_retire.illegal == exp_illegal)
        else begin
            errs[5]++;
            $display("error at %0t: o_retire.illegal = %b, expected %b", $time,
                $sampled(o_retire.illegal), $sampled(exp_illegal));
        end

    a_illegal_no_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && i_retire_ready && exp_illegal |-> !o_retire.wrote)
        else begin
            errs[5]++;
            $display("error at %0t: o_retire.wrote = %b, expected 0", $time,
                $sampled(o_retire.wrote));
        end

    a_wrote_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_retire_valid && i_retire_ready && !exp_illegal |-> o_retire.wrote == exp_wrote)
        else begin
            errs[6]++;
            $display("error at %0t: o_retire.wrote = %b, expected %b", $time,
                $sampled(o_retire.wrote), $sampled(exp_wrote));
        end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d of %0d instructions retired",
            cycle_cnt, ret_idx, N_INSTR);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_instr_ack = 1'b0;
        i_instr_data = '0;
        i_retire_ready = 1'b0;
        rng = 32'h813e;
        ack_wait = -1;
        stall_left = 0;
        stall_done = 1'b0;
        for (int t = 1; t <= 6; t++) begin
            checks[t] = 0;
            errs[t] = 0;
        end
        build_program();
        repeat (RESET_CYCLES) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        wait (req_seen);
        @(posedge i_clk);
        report_test(1, "reset state and first request");
        wait (stall_done && stall_left == 0);
        @(posedge i_clk);
        report_test(4, "retire back-pressure");
        wait (ret_idx == N_INSTR);
        @(posedge i_clk);
        report_test(2, "fetch address sequence");
        report_test(3, "retire order and results");
        report_test(5, "illegal instructions");
        report_test(6, "writes to x0");
        total_checks = 0;
        total_errs = 0;
        for (int t = 1; t <= 6; t++) begin
            total_checks += checks[t];
            total_errs += errs[t];
        end
        $display("6 tests, %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
